//--- logic/cache_pkg.sv
// Request command enum and default cache geometry constants

package cache_pkg;

    // ========================================================================
    // Request commands
    // ========================================================================

    // Command from the cache controller, sampled every cycle
    typedef enum logic [2:0] {
        CMD_NONE       = 3'd0,
        CMD_LOAD       = 3'd1,
        CMD_STORE      = 3'd2,
        // Hit-or-fill variants used while servicing a miss
        CMD_LOAD_MISS  = 3'd3,
        CMD_STORE_MISS = 3'd4
    } req_cmd_e;

    // ========================================================================
    // Default geometry
    // ========================================================================

    // Byte address width
    localparam int DEF_ADDR_W   = 16;
    // One block of data
    localparam int DEF_DATA_W   = 32;
    // 4-byte blocks
    localparam int DEF_OFFSET_W = 2;
    localparam int DEF_NUM_SETS = 4;
    // Associativity
    localparam int DEF_NUM_WAYS = 4;

endpackage

//--- logic/set_lookup.sv
// Set lookup module with tag compare and lowest empty way search

`timescale 1ns/1ps

module set_lookup import cache_pkg::*; #(
    parameter int ADDR_W   = DEF_ADDR_W,
    parameter int OFFSET_W = DEF_OFFSET_W,
    parameter int NUM_SETS = DEF_NUM_SETS,
    parameter int NUM_WAYS = DEF_NUM_WAYS,
    localparam int SET_W   = $clog2(NUM_SETS),
    localparam int TAG_W   = ADDR_W - SET_W - OFFSET_W
) (
    input  logic [ADDR_W-1:0]               req_addr_i,
    input  logic [NUM_WAYS-1:0]             set_valid_i,
    input  logic [NUM_WAYS-1:0][TAG_W-1:0]  set_tags_i,
    output logic                            hit_o,
    output logic [NUM_WAYS-1:0]             hit_way_o,
    output logic                            empty_found_o,
    output logic [NUM_WAYS-1:0]             empty_way_o
);

    logic [TAG_W-1:0] req_tag;

    // Tag sits above index and offset
    assign req_tag = req_addr_i[ADDR_W-1 -: TAG_W];

    // Only valid ways can match
    always_comb begin
        for (int w = 0; w < NUM_WAYS; w++) begin
            hit_way_o[w] = set_valid_i[w] && (set_tags_i[w] == req_tag);
        end
    end

    assign hit_o = |hit_way_o;

    // Priority search, lowest-numbered invalid way wins
    always_comb begin
        empty_way_o = '0;
        for (int w = NUM_WAYS - 1; w >= 0; w--) begin
            if (!set_valid_i[w]) begin
                empty_way_o = '0;
                empty_way_o[w] = 1'b1;
            end
        end
    end

    assign empty_found_o = ~&set_valid_i;

    // Fills only happen on a miss, so a tag never lives twice in one set
    a_hit_onehot0: assert final ($onehot0(hit_way_o))
        else $error("set_lookup: tag matched in more than one way");

endmodule

//--- logic/lru_matrix.sv
// True-LRU pairwise use-history matrix with one-hot LRU way decode

`timescale 1ns/1ps

module lru_matrix import cache_pkg::*; #(
    parameter int NUM_SETS = DEF_NUM_SETS,
    parameter int NUM_WAYS = DEF_NUM_WAYS,
    localparam int SET_W   = $clog2(NUM_SETS),
    localparam int HIST_W  = (NUM_WAYS * (NUM_WAYS - 1)) / 2
) (
    input  logic                 clk_i,
    input  logic                 rst_i,
    input  logic [SET_W-1:0]     set_i,
    input  logic                 access_i,
    input  logic [NUM_WAYS-1:0]  access_way_i,
    output logic [NUM_WAYS-1:0]  lru_way_o
);

    // ========================================================================
    // History storage
    // ========================================================================

    // Bit (i,j), i < j, set when way i was used after way j
    logic [NUM_SETS-1:0][HIST_W-1:0] hist_q;
    logic [HIST_W-1:0]               hist_next;
    logic [HIST_W-1:0]               hist_cur;

    // Flat position of pair (i,j), rows packed upper-triangle style
    function automatic int pair_idx(input int i, input int j);
        return i * NUM_WAYS - (i * (i + 1)) / 2 + (j - i - 1);
    endfunction

    assign hist_cur = hist_q[set_i];

    // ========================================================================
    // Update on access
    // ========================================================================

    // Accessed way becomes newer than every other way of the set
    always_comb begin
        hist_next = hist_cur;
        for (int i = 0; i < NUM_WAYS; i++) begin
            for (int j = i + 1; j < NUM_WAYS; j++) begin
                if (access_way_i[i]) begin
                    hist_next[pair_idx(i, j)] = 1'b1;
                end
                if (access_way_i[j]) begin
                    hist_next[pair_idx(i, j)] = 1'b0;
                end
            end
        end
    end

    // All zero after reset, way 0 oldest
    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            hist_q <= '0;
        end else if (access_i) begin
            hist_q[set_i] <= hist_next;
        end
    end

    // ========================================================================
    // LRU decode
    // ========================================================================

    always_comb begin
        logic older;
        for (int w = 0; w < NUM_WAYS; w++) begin
            older = 1'b1;
            for (int o = 0; o < NUM_WAYS; o++) begin
                // Lower way must be newer, higher way must be older-flag clear
                if (o < w) begin
                    older = older & hist_cur[pair_idx(o, w)];
                end else if (o > w) begin
                    older = older & ~hist_cur[pair_idx(w, o)];
                end
            end
            lru_way_o[w] = older;
        end
    end

    // History always encodes a total order, so exactly one way is oldest
    a_lru_onehot: assert property (@(posedge clk_i) disable iff (rst_i)
        $onehot(lru_way_o))
        else $error("lru_matrix: LRU way is not one-hot");

endmodule

//--- logic/cache_mem_array.sv
// Cache entry array with command decode, fill and replace choice, hit and eviction outputs

`timescale 1ns/1ps

module cache_mem_array import cache_pkg::*; #(
    parameter int ADDR_W   = DEF_ADDR_W,
    parameter int DATA_W   = DEF_DATA_W,
    parameter int OFFSET_W = DEF_OFFSET_W,
    parameter int NUM_SETS = DEF_NUM_SETS,
    parameter int NUM_WAYS = DEF_NUM_WAYS,
    localparam int SET_W   = $clog2(NUM_SETS),
    localparam int TAG_W   = ADDR_W - SET_W - OFFSET_W
) (
    input  logic                            clk_i,
    input  logic                            rst_i,
    input  req_cmd_e                        req_cmd_i,
    input  logic [ADDR_W-1:0]               req_addr_i,
    input  logic [DATA_W-1:0]               req_wdata_i,
    input  logic                            hit_i,
    input  logic [NUM_WAYS-1:0]             hit_way_i,
    input  logic                            empty_found_i,
    input  logic [NUM_WAYS-1:0]             empty_way_i,
    input  logic [NUM_WAYS-1:0]             lru_way_i,
    output logic [SET_W-1:0]                set_idx_o,
    output logic [NUM_WAYS-1:0]             set_valid_o,
    output logic [NUM_WAYS-1:0][TAG_W-1:0]  set_tags_o,
    output logic                            access_o,
    output logic [NUM_WAYS-1:0]             access_way_o,
    output logic                            hit_o,
    output logic [DATA_W-1:0]               rdata_o,
    output logic                            evict_valid_o,
    output logic                            evict_dirty_o,
    output logic [ADDR_W-1:0]               evict_addr_o,
    output logic [DATA_W-1:0]               evict_data_o
);

    // ========================================================================
    // Entry storage
    // ========================================================================

    // Control bits, cleared on reset
    logic [NUM_SETS-1:0][NUM_WAYS-1:0]             valid_q;
    logic [NUM_SETS-1:0][NUM_WAYS-1:0]             dirty_q;
    // Payload
    logic [NUM_SETS-1:0][NUM_WAYS-1:0][TAG_W-1:0]  tag_q;
    logic [NUM_SETS-1:0][NUM_WAYS-1:0][DATA_W-1:0] data_q;

    logic [TAG_W-1:0]    req_tag;
    logic                cmd_valid;
    logic                cmd_write;
    logic                cmd_fill;
    logic                fill_dirty;
    logic                store_hit;
    logic                fill_en;
    logic [NUM_WAYS-1:0] fill_way;
    logic [NUM_WAYS-1:0] wr_way;
    logic                wr_dirty;
    logic [DATA_W-1:0]   hit_data;
    logic [DATA_W-1:0]   victim_data;
    logic [TAG_W-1:0]    victim_tag;
    logic                victim_dirty;

    assign req_tag   = req_addr_i[ADDR_W-1 -: TAG_W];
    assign set_idx_o = req_addr_i[OFFSET_W +: SET_W];

    // Indexed set goes out to the lookup
    assign set_valid_o = valid_q[set_idx_o];
    assign set_tags_o  = tag_q[set_idx_o];

    // ========================================================================
    // Command decode
    // ========================================================================

    always_comb begin
        cmd_valid  = 1'b1;
        cmd_write  = 1'b0;
        cmd_fill   = 1'b0;
        fill_dirty = 1'b0;
        case (req_cmd_i)
            CMD_LOAD: begin
            end
            CMD_STORE: begin
                cmd_write = 1'b1;
            end
            CMD_LOAD_MISS: begin
                cmd_fill = 1'b1;
            end
            CMD_STORE_MISS: begin
                cmd_write  = 1'b1;
                cmd_fill   = 1'b1;
                fill_dirty = 1'b1;
            end
            // Idle and unused encodings leave state alone
            default: begin
                cmd_valid = 1'b0;
            end
        endcase
    end

    assign hit_o     = cmd_valid && hit_i;
    assign store_hit = hit_o && cmd_write;
    // Fill only when the miss variant really misses
    assign fill_en   = cmd_fill && !hit_i;

    // Empty way first, then the LRU victim
    assign fill_way = empty_found_i ? empty_way_i : lru_way_i;

    // Plain misses are not accesses
    assign access_o     = hit_o || fill_en;
    assign access_way_o = hit_o ? hit_way_i : fill_way;

    assign wr_way   = ({NUM_WAYS{store_hit}} & hit_way_i) | ({NUM_WAYS{fill_en}} & fill_way);
    assign wr_dirty = store_hit || (fill_en && fill_dirty);

    // ========================================================================
    // Read and victim select
    // ========================================================================

    // One-hot AND-OR muxes over the indexed set
    always_comb begin
        hit_data     = '0;
        victim_data  = '0;
        victim_tag   = '0;
        victim_dirty = 1'b0;
        for (int w = 0; w < NUM_WAYS; w++) begin
            hit_data     = hit_data | ({DATA_W{hit_way_i[w]}} & data_q[set_idx_o][w]);
            victim_data  = victim_data | ({DATA_W{lru_way_i[w]}} & data_q[set_idx_o][w]);
            victim_tag   = victim_tag | ({TAG_W{lru_way_i[w]}} & tag_q[set_idx_o][w]);
            victim_dirty = victim_dirty | (lru_way_i[w] & dirty_q[set_idx_o][w]);
        end
    end

    // Old data even on a store hit
    assign rdata_o = hit_o ? hit_data : '0;

    // Eviction only when a fill finds the set full
    assign evict_valid_o = fill_en && !empty_found_i;
    assign evict_dirty_o = evict_valid_o && victim_dirty;
    assign evict_addr_o  = evict_valid_o ? {victim_tag, set_idx_o, {OFFSET_W{1'b0}}} : '0;
    assign evict_data_o  = evict_valid_o ? victim_data : '0;

    // ========================================================================
    // State update
    // ========================================================================

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            valid_q <= '0;
            dirty_q <= '0;
        end else begin
            for (int w = 0; w < NUM_WAYS; w++) begin
                if (wr_way[w]) begin
                    valid_q[set_idx_o][w] <= 1'b1;
                    dirty_q[set_idx_o][w] <= wr_dirty;
                end
            end
        end
    end

    always_ff @(posedge clk_i) begin
        for (int w = 0; w < NUM_WAYS; w++) begin
            if (wr_way[w]) begin
                data_q[set_idx_o][w] <= req_wdata_i;
                // Tag changes only when a new block is placed
                if (fill_en) begin
                    tag_q[set_idx_o][w] <= req_tag;
                end
            end
        end
    end

    // Lookup and LRU results together must never pick two ways
    a_one_write: assert property (@(posedge clk_i) disable iff (rst_i)
        $onehot0(wr_way))
        else $error("cache_mem_array: more than one way written");

endmodule

//--- logic/cache_mem.sv
// Cache storage top level joining the entry array, set lookup and LRU matrix

`timescale 1ns/1ps

module cache_mem import cache_pkg::*; #(
    parameter int ADDR_W   = DEF_ADDR_W,
    parameter int DATA_W   = DEF_DATA_W,
    parameter int OFFSET_W = DEF_OFFSET_W,
    parameter int NUM_SETS = DEF_NUM_SETS,
    parameter int NUM_WAYS = DEF_NUM_WAYS,
    localparam int SET_W   = $clog2(NUM_SETS),
    localparam int TAG_W   = ADDR_W - SET_W - OFFSET_W
) (
    input  logic               clk_i,
    input  logic               rst_i,
    input  req_cmd_e           req_cmd_i,
    input  logic [ADDR_W-1:0]  req_addr_i,
    input  logic [DATA_W-1:0]  req_wdata_i,
    output logic               hit_o,
    output logic [DATA_W-1:0]  rdata_o,
    output logic               evict_valid_o,
    output logic               evict_dirty_o,
    output logic [ADDR_W-1:0]  evict_addr_o,
    output logic [DATA_W-1:0]  evict_data_o
);

    // Indexed set from the array
    logic [SET_W-1:0]               set_idx;
    logic [NUM_WAYS-1:0]            set_valid;
    logic [NUM_WAYS-1:0][TAG_W-1:0] set_tags;
    // Lookup results
    logic                           hit;
    logic [NUM_WAYS-1:0]            hit_way;
    logic                           empty_found;
    logic [NUM_WAYS-1:0]            empty_way;
    // LRU traffic
    logic                           access;
    logic [NUM_WAYS-1:0]            access_way;
    logic [NUM_WAYS-1:0]            lru_way;

    cache_mem_array #(
        .ADDR_W   (ADDR_W),
        .DATA_W   (DATA_W),
        .OFFSET_W (OFFSET_W),
        .NUM_SETS (NUM_SETS),
        .NUM_WAYS (NUM_WAYS)
    ) cache_mem_array_i (
        .clk_i         (clk_i),
        .rst_i         (rst_i),
        .req_cmd_i     (req_cmd_i),
        .req_addr_i    (req_addr_i),
        .req_wdata_i   (req_wdata_i),
        .hit_i         (hit),
        .hit_way_i     (hit_way),
        .empty_found_i (empty_found),
        .empty_way_i   (empty_way),
        .lru_way_i     (lru_way),
        .set_idx_o     (set_idx),
        .set_valid_o   (set_valid),
        .set_tags_o    (set_tags),
        .access_o      (access),
        .access_way_o  (access_way),
        .hit_o         (hit_o),
        .rdata_o       (rdata_o),
        .evict_valid_o (evict_valid_o),
        .evict_dirty_o (evict_dirty_o),
        .evict_addr_o  (evict_addr_o),
        .evict_data_o  (evict_data_o)
    );

    set_lookup #(
        .ADDR_W   (ADDR_W),
        .OFFSET_W (OFFSET_W),
        .NUM_SETS (NUM_SETS),
        .NUM_WAYS (NUM_WAYS)
    ) set_lookup_i (
        .req_addr_i    (req_addr_i),
        .set_valid_i   (set_valid),
        .set_tags_i    (set_tags),
        .hit_o         (hit),
        .hit_way_o     (hit_way),
        .empty_found_o (empty_found),
        .empty_way_o   (empty_way)
    );

    lru_matrix #(
        .NUM_SETS (NUM_SETS),
        .NUM_WAYS (NUM_WAYS)
    ) lru_matrix_i (
        .clk_i        (clk_i),
        .rst_i        (rst_i),
        .set_i        (set_idx),
        .access_i     (access),
        .access_way_i (access_way),
        .lru_way_o    (lru_way)
    );

endmodule

//--- dv/clk_gen.sv
// Testbench clock generator with a configurable period

`timescale 1ns/1ps

module clk_gen #(
    parameter int PERIOD_NS = 20
) (
    output logic clk_o
);

    // Low at time zero, first rising edge after half a period
    initial begin
        clk_o = 1'b0;
    end

    always begin
        #(PERIOD_NS / 2);
        clk_o = ~clk_o;
    end

endmodule

//--- dv/cache_mem_tb.sv
// Cache storage testbench with reference model, directed tests, random mix and timeout

`timescale 1ns/1ps

module cache_mem_tb import cache_pkg::*; ();

    localparam int ADDR_W   = DEF_ADDR_W;
    localparam int DATA_W   = DEF_DATA_W;
    localparam int OFFSET_W = DEF_OFFSET_W;
    localparam int SETS     = DEF_NUM_SETS;
    localparam int WAYS     = DEF_NUM_WAYS;
    localparam int SET_W    = $clog2(SETS);
    localparam int TAG_W    = ADDR_W - SET_W - OFFSET_W;
    // Roughly four times the length of all tests together
    localparam int TIMEOUT_CYCLES = 2000;

    logic              clk;
    logic              rst       = 1'b1;
    req_cmd_e          req_cmd   = CMD_NONE;
    logic [ADDR_W-1:0] req_addr  = '0;
    logic [DATA_W-1:0] req_wdata = '0;
    logic              hit;
    logic [DATA_W-1:0] rdata;
    logic              evict_valid;
    logic              evict_dirty;
    logic [ADDR_W-1:0] evict_addr;
    logic [DATA_W-1:0] evict_data;

    int     cycle_cnt = 0;
    integer seed      = 32'hfeb2_39c2;

    // Reference model of every entry with a use stamp per way for age
    logic              m_valid [SETS][WAYS];
    logic              m_dirty [SETS][WAYS];
    logic [TAG_W-1:0]  m_tag   [SETS][WAYS];
    logic [DATA_W-1:0] m_data  [SETS][WAYS];
    int                m_stamp [SETS][WAYS];
    int                tick;

    clk_gen #(.PERIOD_NS(20)) clk_gen_i (.clk_o(clk));

    cache_mem cache_mem_i (
        .clk_i         (clk),
        .rst_i         (rst),
        .req_cmd_i     (req_cmd),
        .req_addr_i    (req_addr),
        .req_wdata_i   (req_wdata),
        .hit_o         (hit),
        .rdata_o       (rdata),
        .evict_valid_o (evict_valid),
        .evict_dirty_o (evict_dirty),
        .evict_addr_o  (evict_addr),
        .evict_data_o  (evict_data)
    );

    // ========================================================================
    // Helpers
    // ========================================================================

    function automatic logic [ADDR_W-1:0] make_addr(input logic [TAG_W-1:0] tag, input int set);
        return {tag, SET_W'(set), {OFFSET_W{1'b0}}};
    endfunction

    // Oldest way has the smallest stamp
    function automatic int lru_way_of(input int set);
        int best;
        best = 0;
        for (int w = 1; w < WAYS; w++) begin
            if (m_stamp[set][w] < m_stamp[set][best]) begin
                best = w;
            end
        end
        return best;
    endfunction

    // Empty cache with way 0 oldest and the highest way newest
    function automatic void model_reset();
        for (int s = 0; s < SETS; s++) begin
            for (int w = 0; w < WAYS; w++) begin
                m_valid[s][w] = 1'b0;
                m_dirty[s][w] = 1'b0;
                m_stamp[s][w] = w;
            end
        end
        tick = WAYS;
    endfunction

    task automatic check_val(input string name, input logic [63:0] got, input logic [63:0] exp);
        if (got !== exp) begin
            $display("ERR %0t %s got %0h expected %0h", $time, name, got, exp);
            $display("Regression failed");
            $fatal(1, "stopping at first mismatch");
        end
    endtask

    task automatic apply_reset();
        @(posedge clk);
        rst     <= 1'b1;
        req_cmd <= CMD_NONE;
        repeat (10) @(posedge clk);
        rst <= 1'b0;
        model_reset();
    endtask

    // Drive one request, check all outputs against the model, then advance the model
    task automatic send_req(input req_cmd_e cmd, input logic [ADDR_W-1:0] addr,
                            input logic [DATA_W-1:0] wdata);
        logic [SET_W-1:0] s;
        logic [TAG_W-1:0] tag;
        int               hw;
        int               ew;
        int               vw;
        logic             e_hit;
        logic             is_fill;
        logic             e_ev;
        logic             is_store;
        @(posedge clk);
        req_cmd   <= cmd;
        req_addr  <= addr;
        req_wdata <= wdata;
        @(negedge clk);
        s   = addr[OFFSET_W +: SET_W];
        tag = addr[ADDR_W-1 -: TAG_W];
        hw  = -1;
        ew  = -1;
        // Downward scan leaves the lowest empty way
        for (int w = WAYS - 1; w >= 0; w--) begin
            if (m_valid[s][w] && m_tag[s][w] == tag) begin
                hw = w;
            end
            if (!m_valid[s][w]) begin
                ew = w;
            end
        end
        is_store = (cmd == CMD_STORE) || (cmd == CMD_STORE_MISS);
        e_hit    = (cmd != CMD_NONE) && (hw >= 0);
        is_fill  = ((cmd == CMD_LOAD_MISS) || (cmd == CMD_STORE_MISS)) && (hw < 0);
        vw       = (ew >= 0) ? ew : lru_way_of(s);
        e_ev     = is_fill && (ew < 0);
        check_val("hit_o", hit, e_hit);
        check_val("evict_valid_o", evict_valid, e_ev);
        if (e_hit) begin
            check_val("rdata_o", rdata, m_data[s][hw]);
        end else begin
            check_val("rdata_o", rdata, 0);
        end
        if (e_ev) begin
            check_val("evict_dirty_o", evict_dirty, m_dirty[s][vw]);
            check_val("evict_addr_o", evict_addr, {m_tag[s][vw], s, {OFFSET_W{1'b0}}});
            check_val("evict_data_o", evict_data, m_data[s][vw]);
        end else begin
            check_val("evict_dirty_o", evict_dirty, 0);
            check_val("evict_addr_o", evict_addr, 0);
            check_val("evict_data_o", evict_data, 0);
        end
        // Hits and fills count as accesses and plain misses leave state alone
        if (e_hit) begin
            m_stamp[s][hw] = tick;
            tick++;
            if (is_store) begin
                m_data[s][hw]  = wdata;
                m_dirty[s][hw] = 1'b1;
            end
        end else if (is_fill) begin
            m_valid[s][vw] = 1'b1;
            m_tag[s][vw]   = tag;
            m_data[s][vw]  = wdata;
            m_dirty[s][vw] = (cmd == CMD_STORE_MISS);
            m_stamp[s][vw] = tick;
            tick++;
        end
    endtask

    task automatic expect_quiet();
        check_val("hit_o", hit, 0);
        check_val("rdata_o", rdata, 0);
        check_val("evict_valid_o", evict_valid, 0);
        check_val("evict_data_o", evict_data, 0);
    endtask

    task automatic expect_evict(input logic [ADDR_W-1:0] addr, input logic [DATA_W-1:0] data,
                                input logic dirty);
        check_val("evict_valid_o", evict_valid, 1);
        check_val("evict_addr_o", evict_addr, addr);
        check_val("evict_data_o", evict_data, data);
        check_val("evict_dirty_o", evict_dirty, dirty);
    endtask

    // ========================================================================
    // Directed tests
    // ========================================================================

    task automatic empty_after_reset();
        for (int i = 0; i < SETS; i++) begin
            send_req(CMD_LOAD, make_addr(TAG_W'(12'h010 + i), i), '0);
            expect_quiet();
        end
        // A plain STORE miss must not place a block
        send_req(CMD_STORE, make_addr(12'h020, 1), 32'hdead_beef);
        expect_quiet();
        send_req(CMD_LOAD, make_addr(12'h020, 1), '0);
        expect_quiet();
        send_req(CMD_NONE, make_addr(12'h020, 1), '0);
        expect_quiet();
    endtask

    task automatic fill_then_hit();
        logic [ADDR_W-1:0] a;
        a = make_addr(12'h123, 1);
        send_req(CMD_LOAD_MISS, a, 32'h1111_aaaa);
        check_val("hit_o", hit, 0);
        send_req(CMD_LOAD, a, '0);
        check_val("rdata_o", rdata, 32'h1111_aaaa);
        // Offset bits select nothing inside a block
        send_req(CMD_LOAD, a | 16'h0003, '0);
        check_val("hit_o", hit, 1);
        send_req(CMD_STORE, a, 32'h2222_bbbb);
        check_val("rdata_o", rdata, 32'h1111_aaaa);
        send_req(CMD_LOAD, a, '0);
        check_val("rdata_o", rdata, 32'h2222_bbbb);
        send_req(CMD_NONE, a, '0);
        check_val("hit_o", hit, 0);
    endtask

    task automatic replacement_order();
        for (int i = 0; i < WAYS; i++) begin
            send_req(CMD_LOAD_MISS, make_addr(TAG_W'(12'h200 + i), 2), 32'h3000_0000 + i);
            check_val("evict_valid_o", evict_valid, 0);
        end
        // Full set gives up its first-filled block
        send_req(CMD_LOAD_MISS, make_addr(12'h2ff, 2), 32'h3000_00ff);
        expect_evict(make_addr(12'h200, 2), 32'h3000_0000, 1'b0);
        send_req(CMD_LOAD, make_addr(12'h200, 2), '0);
        check_val("hit_o", hit, 0);
    endtask

    task automatic recency_update();
        // Way 0 placed dirty and the rest clean
        send_req(CMD_STORE_MISS, make_addr(12'h400, 3), 32'h4000_0000);
        for (int i = 1; i < WAYS; i++) begin
            send_req(CMD_LOAD_MISS, make_addr(TAG_W'(12'h400 + i), 3), 32'h4000_0000 + i);
        end
        send_req(CMD_LOAD, make_addr(12'h400, 3), '0);
        check_val("hit_o", hit, 1);
        send_req(CMD_LOAD_MISS, make_addr(12'h404, 3), 32'h4000_0004);
        expect_evict(make_addr(12'h401, 3), 32'h4000_0001, 1'b0);
        send_req(CMD_STORE, make_addr(12'h402, 3), 32'h4444_5555);
        check_val("rdata_o", rdata, 32'h4000_0002);
        // Age order now 403, 400, 404, 402
        send_req(CMD_LOAD_MISS, make_addr(12'h405, 3), 32'h4000_0005);
        expect_evict(make_addr(12'h403, 3), 32'h4000_0003, 1'b0);
        send_req(CMD_LOAD_MISS, make_addr(12'h406, 3), 32'h4000_0006);
        expect_evict(make_addr(12'h400, 3), 32'h4000_0000, 1'b1);
        send_req(CMD_LOAD_MISS, make_addr(12'h407, 3), 32'h4000_0007);
        expect_evict(make_addr(12'h404, 3), 32'h4000_0004, 1'b0);
        send_req(CMD_LOAD_MISS, make_addr(12'h408, 3), 32'h4000_0008);
        expect_evict(make_addr(12'h402, 3), 32'h4444_5555, 1'b1);
    endtask

    // Six tags over four ways keep hits and evictions frequent
    task automatic random_mix();
        logic [TAG_W-1:0]  pool [6];
        logic [ADDR_W-1:0] addr;
        req_cmd_e          cmd;
        int                n;
        pool = '{12'h015, 12'h2a3, 12'h3c0, 12'h7f1, 12'h9e4, 12'hb06};
        for (int i = 0; i < 300; i++) begin
            n    = $unsigned($random(seed)) % 5;
            cmd  = req_cmd_e'(3'(n));
            n    = $unsigned($random(seed)) % 6;
            addr = make_addr(pool[n], $unsigned($random(seed)) % SETS);
            addr[OFFSET_W-1:0] = OFFSET_W'($random(seed));
            send_req(cmd, addr, $random(seed));
        end
    endtask

    // ========================================================================
    // Sequence and timeout
    // ========================================================================

    initial begin
        apply_reset();
        empty_after_reset();
        apply_reset();
        fill_then_hit();
        apply_reset();
        replacement_order();
        apply_reset();
        recency_update();
        apply_reset();
        random_mix();
        @(posedge clk);
        $display("Regression passed");
        $finish;
    end

    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt == TIMEOUT_CYCLES) begin
            $display("Run timed out after %0d cycles before the tests finished", TIMEOUT_CYCLES);
            $display("Regression failed");
            $fatal(1, "timeout");
        end
    end

endmodule

//--- files.f
logic/cache_pkg.sv
logic/set_lookup.sv
logic/lru_matrix.sv
logic/cache_mem_array.sv
logic/cache_mem.sv
dv/clk_gen.sv
dv/cache_mem_tb.sv

//--- Makefile
VERILATOR := verilator
FLAGS     := --timing --assert
SIM_FLAGS := --binary -Wno-fatal
TOP       := cache_mem_tb
RTL_TOP   := cache_mem
FILELIST  := files.f
BUILD_DIR := obj_dir
PASS_MSG  := Regression passed

.PHONY: lint sim clean

lint:
	$(VERILATOR) --lint-only $(FLAGS) -f $(FILELIST) --top-module $(RTL_TOP)
	$(VERILATOR) --lint-only $(FLAGS) -f $(FILELIST) --top-module $(TOP)

$(BUILD_DIR)/V$(TOP): $(shell cat $(FILELIST))
	$(VERILATOR) $(SIM_FLAGS) $(FLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(BUILD_DIR)

sim: $(BUILD_DIR)/V$(TOP)
	@out="$$(./$(BUILD_DIR)/V$(TOP) 2>&1)"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)
